//--- filelist.f
rtl/periph_xbar_pkg.sv
rtl/periph_addr_decoder.sv
rtl/periph_rr_arbiter.sv
rtl/periph_resp_router.sv
rtl/periph_xbar.sv
test/periph_xbar_assert.sv
test/periph_xbar_tb.sv

//--- rtl/periph_addr_decoder.sv
// Peripheral address decoder that steers one master request to its slave and returns the grant
`timescale 1ns/100ps

module periph_addr_decoder (
  input  logic                                  req_i,
  input  periph_xbar_pkg::addr_t                addr_i,
  input  logic [periph_xbar_pkg::NB_SLAVES-1:0] slv_gnt_i,
  output logic [periph_xbar_pkg::NB_SLAVES-1:0] slv_req_o,
  output logic                                  gnt_o
);

  import periph_xbar_pkg::*;

  slv_idx_t   slv_idx;
  slv_idx_t   route;
  logic [7:0] cluster_field;
  logic [3:0] region_field;
  logic       in_window;

  assign cluster_field = addr_i[ADDR_WIDTH-1:ADDR_WIDTH-8];
  assign region_field  = addr_i[ADDR_WIDTH-9:ADDR_WIDTH-12];
  assign route         = addr_i[ROUTE_MSB:ROUTE_LSB];

  // Anything outside this cluster's peripheral and reserved regions leaves the cluster
  assign in_window = (cluster_field == CLUSTER_BASE) &&
                     ((region_field == PERIPH_REGION) || (region_field == RESERVED_REGION));

  always_comb begin
    if (!in_window) begin
      slv_idx = SPER_EXT_ID;
    end else if ((region_field == RESERVED_REGION) || addr_i[ROUTE_MSB+1]) begin
      slv_idx = SPER_ERROR_ID;
    end else if ((route >= SPER_EVENT_U_ID) && (route < SPER_EVENT_U_ID + NB_EU_PLUGS)) begin
      // All event unit aliases share one port
      slv_idx = SPER_EVENT_U_ID;
    end else if (route == SPER_EXT_ID) begin
      // Direct access to the external port would loop back out, send it to the error slave
      slv_idx = SPER_ERROR_ID;
    end else begin
      slv_idx = route;
    end
  end

  // One-hot request towards the selected slave only
  always_comb begin
    slv_req_o          = '0;
    slv_req_o[slv_idx] = req_i;
  end

  // Arbiters only grant requesting masters, so no extra qualification here
  assign gnt_o = slv_gnt_i[slv_idx];

endmodule

//--- rtl/periph_resp_router.sv
// Response router that picks the slave response addressed to one master
`timescale 1ns/100ps

module periph_resp_router #(
  parameter int NB_MASTERS = 4,
  parameter int MASTER_IDX = 0
) (
  input  logic                   [periph_xbar_pkg::NB_SLAVES-1:0]                 slv_r_valid_i,
  input  logic                   [periph_xbar_pkg::NB_SLAVES-1:0][NB_MASTERS-1:0] slv_r_id_i,
  input  periph_xbar_pkg::data_t [periph_xbar_pkg::NB_SLAVES-1:0]                 slv_r_rdata_i,
  input  logic                   [periph_xbar_pkg::NB_SLAVES-1:0]                 slv_r_opc_i,
  output logic                                                                    r_valid_o,
  output periph_xbar_pkg::data_t                                                  r_rdata_o,
  output logic                                                                    r_opc_o
);

  import periph_xbar_pkg::*;

  logic [NB_SLAVES-1:0] hit;
  slv_idx_t             sel;

  // A slave response belongs here when it is valid and carries this master's id bit
  for (genvar s = 0; s < NB_SLAVES; s++) begin : gen_hit
    assign hit[s] = slv_r_valid_i[s] & slv_r_id_i[s][MASTER_IDX];
  end

  // One-hot to index, at most one slave answers a master per cycle
  always_comb begin
    sel = '0;
    for (int s = 0; s < NB_SLAVES; s++) begin
      if (hit[s]) begin
        sel = sel | slv_idx_t'(s);
      end
    end
  end

  assign r_valid_o = |hit;
  assign r_rdata_o = slv_r_rdata_i[sel];
  assign r_opc_o   = slv_r_opc_i[sel];

endmodule

//--- rtl/periph_rr_arbiter.sv
// Round-robin arbiter for one peripheral slave port with request field mux
`timescale 1ns/100ps

module periph_rr_arbiter #(
  parameter int NB_MASTERS = 4
) (
  input  logic                                           clk_i,
  input  logic                                           rst_i,
  input  logic                   [NB_MASTERS-1:0]        req_i,
  input  periph_xbar_pkg::addr_t [NB_MASTERS-1:0]        mst_addr_i,
  input  logic                   [NB_MASTERS-1:0]        mst_wen_i,
  input  periph_xbar_pkg::data_t [NB_MASTERS-1:0]        mst_wdata_i,
  input  periph_xbar_pkg::be_t   [NB_MASTERS-1:0]        mst_be_i,
  input  logic                                           slv_gnt_i,
  output logic                   [NB_MASTERS-1:0]        gnt_o,
  output logic                                           slv_req_o,
  output periph_xbar_pkg::addr_t                         slv_addr_o,
  output logic                                           slv_wen_o,
  output periph_xbar_pkg::data_t                         slv_wdata_o,
  output periph_xbar_pkg::be_t                           slv_be_o,
  output logic                   [NB_MASTERS-1:0]        slv_id_o
);

  localparam int IDX_WIDTH = (NB_MASTERS > 1) ? $clog2(NB_MASTERS) : 1;

  typedef logic [IDX_WIDTH-1:0] mst_idx_t;

  mst_idx_t              ptr_q;
  mst_idx_t              ptr_next;
  mst_idx_t              winner;
  logic                  any_req;
  logic [NB_MASTERS-1:0] winner_oh;
  logic                  handshake;

  // Scan upward from the pointer and wrap, first requester wins
  always_comb begin : pick_winner
    int cand;
    any_req = 1'b0;
    winner  = ptr_q;
    for (int k = 0; k < NB_MASTERS; k++) begin
      cand = (int'(ptr_q) + k) % NB_MASTERS;
      if (!any_req && req_i[cand]) begin
        any_req = 1'b1;
        winner  = mst_idx_t'(cand);
      end
    end
  end

  always_comb begin
    winner_oh         = '0;
    winner_oh[winner] = 1'b1;
  end

  assign handshake = any_req & slv_gnt_i;

  // Request and payload go straight through from the winner
  assign slv_req_o   = any_req;
  assign slv_addr_o  = mst_addr_i[winner];
  assign slv_wen_o   = mst_wen_i[winner];
  assign slv_wdata_o = mst_wdata_i[winner];
  assign slv_be_o    = mst_be_i[winner];
  assign slv_id_o    = winner_oh;

  assign gnt_o = handshake ? winner_oh : '0;

  // Winner gets lowest priority in the next round
  assign ptr_next = (winner == mst_idx_t'(NB_MASTERS - 1)) ? '0 : winner + 1'b1;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ptr_q <= '0;
    end else if (handshake) begin
      ptr_q <= ptr_next;
    end
  end

endmodule

//--- rtl/periph_xbar.sv
// Peripheral crossbar connecting cluster masters to eight peripheral slave ports
`timescale 1ns/100ps

module periph_xbar #(
  parameter int NB_MASTERS = 4
) (
  input  logic                                                    clk_i,
  input  logic                                                    rst_i,

  // Master ports
  input  logic                   [NB_MASTERS-1:0]                 mst_req_i,
  input  periph_xbar_pkg::addr_t [NB_MASTERS-1:0]                 mst_addr_i,
  input  logic                   [NB_MASTERS-1:0]                 mst_wen_i,
  input  periph_xbar_pkg::data_t [NB_MASTERS-1:0]                 mst_wdata_i,
  input  periph_xbar_pkg::be_t   [NB_MASTERS-1:0]                 mst_be_i,
  output logic                   [NB_MASTERS-1:0]                 mst_gnt_o,
  output logic                   [NB_MASTERS-1:0]                 mst_r_valid_o,
  output periph_xbar_pkg::data_t [NB_MASTERS-1:0]                 mst_r_rdata_o,
  output logic                   [NB_MASTERS-1:0]                 mst_r_opc_o,

  // Slave ports
  output logic                   [periph_xbar_pkg::NB_SLAVES-1:0] slv_req_o,
  output periph_xbar_pkg::addr_t [periph_xbar_pkg::NB_SLAVES-1:0] slv_addr_o,
  output logic                   [periph_xbar_pkg::NB_SLAVES-1:0] slv_wen_o,
  output periph_xbar_pkg::data_t [periph_xbar_pkg::NB_SLAVES-1:0] slv_wdata_o,
  output periph_xbar_pkg::be_t   [periph_xbar_pkg::NB_SLAVES-1:0] slv_be_o,
  output logic [periph_xbar_pkg::NB_SLAVES-1:0][NB_MASTERS-1:0]   slv_id_o,
  input  logic                   [periph_xbar_pkg::NB_SLAVES-1:0] slv_gnt_i,
  input  logic                   [periph_xbar_pkg::NB_SLAVES-1:0] slv_r_valid_i,
  input  periph_xbar_pkg::data_t [periph_xbar_pkg::NB_SLAVES-1:0] slv_r_rdata_i,
  input  logic                   [periph_xbar_pkg::NB_SLAVES-1:0] slv_r_opc_i,
  input  logic [periph_xbar_pkg::NB_SLAVES-1:0][NB_MASTERS-1:0]   slv_r_id_i
);

  import periph_xbar_pkg::*;

  // Request and grant matrices, indexed by master on the decoder side
  logic [NB_MASTERS-1:0][NB_SLAVES-1:0] mst_slv_req;
  logic [NB_MASTERS-1:0][NB_SLAVES-1:0] mst_slv_gnt;

  // Same matrices indexed by slave on the arbiter side
  logic [NB_SLAVES-1:0][NB_MASTERS-1:0] slv_mst_req;
  logic [NB_SLAVES-1:0][NB_MASTERS-1:0] slv_mst_gnt;

  for (genvar m = 0; m < NB_MASTERS; m++) begin : gen_transpose_m
    for (genvar s = 0; s < NB_SLAVES; s++) begin : gen_transpose_s
      assign slv_mst_req[s][m] = mst_slv_req[m][s];
      assign mst_slv_gnt[m][s] = slv_mst_gnt[s][m];
    end
  end

  // Master side, one decoder and one response router each
  for (genvar m = 0; m < NB_MASTERS; m++) begin : gen_master
    periph_addr_decoder i_decoder (
      .req_i     (mst_req_i[m]),
      .addr_i    (mst_addr_i[m]),
      .slv_gnt_i (mst_slv_gnt[m]),
      .slv_req_o (mst_slv_req[m]),
      .gnt_o     (mst_gnt_o[m])
    );

    periph_resp_router #(
      .NB_MASTERS (NB_MASTERS),
      .MASTER_IDX (m)
    ) i_resp_router (
      .slv_r_valid_i (slv_r_valid_i),
      .slv_r_id_i    (slv_r_id_i),
      .slv_r_rdata_i (slv_r_rdata_i),
      .slv_r_opc_i   (slv_r_opc_i),
      .r_valid_o     (mst_r_valid_o[m]),
      .r_rdata_o     (mst_r_rdata_o[m]),
      .r_opc_o       (mst_r_opc_o[m])
    );
  end

  // Slave side, one round-robin arbiter per port
  for (genvar s = 0; s < NB_SLAVES; s++) begin : gen_slave
    periph_rr_arbiter #(
      .NB_MASTERS (NB_MASTERS)
    ) i_arbiter (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .req_i       (slv_mst_req[s]),
      .mst_addr_i  (mst_addr_i),
      .mst_wen_i   (mst_wen_i),
      .mst_wdata_i (mst_wdata_i),
      .mst_be_i    (mst_be_i),
      .slv_gnt_i   (slv_gnt_i[s]),
      .gnt_o       (slv_mst_gnt[s]),
      .slv_req_o   (slv_req_o[s]),
      .slv_addr_o  (slv_addr_o[s]),
      .slv_wen_o   (slv_wen_o[s]),
      .slv_wdata_o (slv_wdata_o[s]),
      .slv_be_o    (slv_be_o[s]),
      .slv_id_o    (slv_id_o[s])
    );
  end

endmodule

//--- rtl/periph_xbar_pkg.sv
// Peripheral crossbar package with bus widths, slave map and address decode constants
package periph_xbar_pkg;

  // Bus widths
  localparam int ADDR_WIDTH    = 32;
  localparam int DATA_WIDTH    = 32;
  localparam int BE_WIDTH      = DATA_WIDTH / 8;

  // Slave side of the crossbar
  localparam int NB_SLAVES     = 8;
  localparam int SLV_IDX_WIDTH = $clog2(NB_SLAVES);

  typedef logic [ADDR_WIDTH-1:0]    addr_t;
  typedef logic [DATA_WIDTH-1:0]    data_t;
  typedef logic [BE_WIDTH-1:0]      be_t;
  typedef logic [SLV_IDX_WIDTH-1:0] slv_idx_t;

  // Cluster address map, bits 31:24 select the cluster
  localparam logic [7:0] CLUSTER_BASE    = 8'h10;

  // Bits 23:20 select the region inside the cluster
  localparam logic [3:0] PERIPH_REGION   = 4'h2;
  localparam logic [3:0] RESERVED_REGION = 4'h3;

  // Routing field inside the peripheral window
  // The bit just above ROUTE_MSB must be clear for a valid peripheral access
  localparam int ROUTE_LSB = 16;
  localparam int ROUTE_MSB = 18;

  // Slave indices with a special role
  localparam slv_idx_t SPER_EVENT_U_ID = 3'd4;
  localparam int       NB_EU_PLUGS     = 2;
  localparam slv_idx_t SPER_ERROR_ID   = 3'd6;
  localparam slv_idx_t SPER_EXT_ID     = 3'd7;

endpackage

//--- test/periph_xbar_assert.sv
// Protocol assertions on the peripheral crossbar ports, bound into the crossbar
`timescale 1ns/100ps

module periph_xbar_assert #(
  parameter int NB_MASTERS = 4
) (
  input logic                                                  clk_i,
  input logic                                                  rst_i,
  input logic                   [NB_MASTERS-1:0]               mst_req_i,
  input periph_xbar_pkg::addr_t [NB_MASTERS-1:0]               mst_addr_i,
  input logic                   [NB_MASTERS-1:0]               mst_gnt_i,
  input logic [periph_xbar_pkg::NB_SLAVES-1:0]                 slv_req_i,
  input logic [periph_xbar_pkg::NB_SLAVES-1:0][NB_MASTERS-1:0] slv_id_i,
  input logic [periph_xbar_pkg::NB_SLAVES-1:0]                 slv_r_valid_i,
  input logic [periph_xbar_pkg::NB_SLAVES-1:0][NB_MASTERS-1:0] slv_r_id_i
);

  import periph_xbar_pkg::*;

  int fail_count = 0;

  for (genvar m = 0; m < NB_MASTERS; m++) begin : gen_mst
    logic [NB_SLAVES-1:0] resp_hit;

    for (genvar s = 0; s < NB_SLAVES; s++) begin : gen_hit
      assign resp_hit[s] = slv_r_valid_i[s] & slv_r_id_i[s][m];
    end

    // Request and address hold until the grant
    req_held: assert property (@(posedge clk_i) disable iff (rst_i)
      mst_req_i[m] && !mst_gnt_i[m] |=> mst_req_i[m] && $stable(mst_addr_i[m]))
      else begin
        $error("master %0d changed its request before the grant", m);
        fail_count++;
      end

    one_resp: assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(resp_hit))
      else begin
        $error("master %0d got responses from several slaves", m);
        fail_count++;
      end
  end

  // The forwarded id names exactly one master, and that master is requesting
  for (genvar s = 0; s < NB_SLAVES; s++) begin : gen_slv
    id_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
      slv_req_i[s] |-> $onehot(slv_id_i[s]) && ((slv_id_i[s] & mst_req_i) != '0))
      else begin
        $error("slave %0d request carries id %b", s, slv_id_i[s]);
        fail_count++;
      end
  end

endmodule

bind periph_xbar periph_xbar_assert #(
  .NB_MASTERS (NB_MASTERS)
) i_assert (
  .clk_i         (clk_i),
  .rst_i         (rst_i),
  .mst_req_i     (mst_req_i),
  .mst_addr_i    (mst_addr_i),
  .mst_gnt_i     (mst_gnt_o),
  .slv_req_i     (slv_req_o),
  .slv_id_i      (slv_id_o),
  .slv_r_valid_i (slv_r_valid_i),
  .slv_r_id_i    (slv_r_id_i)
);

//--- test/periph_xbar_tb.sv
// Directed testbench for the peripheral crossbar with simple slave models
`timescale 1ns/100ps

module periph_xbar_tb;

  import periph_xbar_pkg::*;

  localparam int NB_MASTERS   = 4;
  localparam int WAIT_LIMIT   = 16;
  localparam int STALL_CYCLES = 6;

  logic                                  clk_i;
  logic                                  rst_i;
  logic  [NB_MASTERS-1:0]                mst_req_i;
  addr_t [NB_MASTERS-1:0]                mst_addr_i;
  logic  [NB_MASTERS-1:0]                mst_wen_i;
  data_t [NB_MASTERS-1:0]                mst_wdata_i;
  be_t   [NB_MASTERS-1:0]                mst_be_i;
  logic  [NB_MASTERS-1:0]                mst_gnt_o;
  logic  [NB_MASTERS-1:0]                mst_r_valid_o;
  data_t [NB_MASTERS-1:0]                mst_r_rdata_o;
  logic  [NB_MASTERS-1:0]                mst_r_opc_o;
  logic  [NB_SLAVES-1:0]                 slv_req_o;
  addr_t [NB_SLAVES-1:0]                 slv_addr_o;
  logic  [NB_SLAVES-1:0]                 slv_wen_o;
  data_t [NB_SLAVES-1:0]                 slv_wdata_o;
  be_t   [NB_SLAVES-1:0]                 slv_be_o;
  logic  [NB_SLAVES-1:0][NB_MASTERS-1:0] slv_id_o;
  logic  [NB_SLAVES-1:0]                 slv_gnt_i;
  logic  [NB_SLAVES-1:0]                 slv_r_valid_i;
  data_t [NB_SLAVES-1:0]                 slv_r_rdata_i;
  logic  [NB_SLAVES-1:0]                 slv_r_opc_i;
  logic  [NB_SLAVES-1:0][NB_MASTERS-1:0] slv_r_id_i;

  // Slave model state
  logic  [NB_SLAVES-1:0]                 pend_valid;
  addr_t [NB_SLAVES-1:0]                 pend_addr;
  logic  [NB_SLAVES-1:0][NB_MASTERS-1:0] pend_id;
  int                                    hs_count [NB_SLAVES];

  integer seed;
  int     errors;
  int     checks;
  int     tests;

  periph_xbar #(.NB_MASTERS(NB_MASTERS)) dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // Slaves take a request on a handshake and answer it one cycle later
  always @(posedge clk_i) begin
    for (int s = 0; s < NB_SLAVES; s++) begin
      if (rst_i) begin
        pend_valid[s] <= 1'b0;
        hs_count[s]   <= 0;
      end else begin
        pend_valid[s] <= slv_req_o[s] & slv_gnt_i[s];
        pend_addr[s]  <= slv_addr_o[s];
        pend_id[s]    <= slv_id_o[s];
        if (slv_req_o[s] && slv_gnt_i[s]) begin
          hs_count[s] <= hs_count[s] + 1;
        end
      end
    end
  end

  always @(negedge clk_i) begin
    for (int s = 0; s < NB_SLAVES; s++) begin
      slv_r_valid_i[s] <= pend_valid[s];
      slv_r_rdata_i[s] <= pend_addr[s] ^ slave_key(s);
      slv_r_opc_i[s]   <= pend_addr[s][2];
      slv_r_id_i[s]    <= pend_id[s];
    end
  end

  function automatic data_t slave_key(input int s);
    return 32'h5a00_0000 | (s << 8) | s;
  endfunction

  // Reference address map
  function automatic int expected_slave(input addr_t a);
    if (a[31:24] != CLUSTER_BASE ||
        (a[23:20] != PERIPH_REGION && a[23:20] != RESERVED_REGION)) begin
      return SPER_EXT_ID;
    end
    if (a[23:20] == RESERVED_REGION || a[19]) begin
      return SPER_ERROR_ID;
    end
    case (a[18:16])
      3'd4, 3'd5: return SPER_EVENT_U_ID;
      3'd7:       return SPER_ERROR_ID;
      default:    return a[18:16];
    endcase
  endfunction

  task automatic check_that(input bit cond, input string msg);
    checks++;
    assert (cond) else begin
      $display("[FAIL] %0d ns: %s", $time, msg);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int start);
    tests++;
    $display("%-18s %s (%0d errors)", name, (errors == start) ? "ok" : "failed", errors - start);
  endtask

  // Waits at rising edges for a grant, or for a response when resp is set
  task automatic wait_for(input int m, input bit resp, output bit ok);
    int waited;
    waited = 0;
    @(posedge clk_i);
    while (!(resp ? mst_r_valid_o[m] : mst_gnt_o[m]) && waited < WAIT_LIMIT) begin
      waited++;
      @(posedge clk_i);
    end
    ok = resp ? mst_r_valid_o[m] : mst_gnt_o[m];
    if (!ok) begin
      $display("ERROR: master %0d timed out waiting for %s", m, resp ? "a response" : "a grant");
      errors++;
    end
  endtask

  // One access, checked at the slave port in the grant cycle and at the master on return
  task automatic access(input int m, input addr_t addr, input logic wen, input data_t wdata,
                        input be_t be, input bit alone);
    int exp;
    bit ok;
    exp = expected_slave(addr);
    @(negedge clk_i);
    mst_req_i[m]   = 1'b1;
    mst_addr_i[m]  = addr;
    mst_wen_i[m]   = wen;
    mst_wdata_i[m] = wdata;
    mst_be_i[m]    = be;
    wait_for(m, 1'b0, ok);
    if (ok) begin
      check_that(alone ? (slv_req_o == (1 << exp)) : slv_req_o[exp],
                 $sformatf("addr %h reached slaves %b, expected %0d", addr, slv_req_o, exp));
      check_that(slv_addr_o[exp] == addr && slv_wen_o[exp] == wen && slv_id_o[exp] == (1 << m) &&
                 (wen || (slv_wdata_o[exp] == wdata && slv_be_o[exp] == be)),
                 $sformatf("slave %0d got addr %h id %b from master %0d",
                           exp, slv_addr_o[exp], slv_id_o[exp], m));
    end
    @(negedge clk_i);
    mst_req_i[m] = 1'b0;
    if (ok) begin
      wait_for(m, 1'b1, ok);
    end
    if (ok) begin
      // The crossbar adds no latency, the slave answers in this very cycle
      check_that(slv_r_valid_i[exp] && slv_r_id_i[exp] == (1 << m),
                 $sformatf("response to master %0d not in the cycle slave %0d answered",
                           m, exp));
      check_that(mst_r_rdata_o[m] == (addr ^ slave_key(exp)) && mst_r_opc_o[m] == addr[2],
                 $sformatf("master %0d read %h opc %b for addr %h",
                           m, mst_r_rdata_o[m], mst_r_opc_o[m], addr));
    end
  endtask

  // Masters in who request slave 1 together, grants follow wrap order from first
  task automatic arbitrate_round(input logic [NB_MASTERS-1:0] who, input int first);
    logic [NB_MASTERS-1:0] g;
    int want;
    int waited;
    want   = first;
    waited = 0;
    @(negedge clk_i);
    for (int m = 0; m < NB_MASTERS; m++) begin
      mst_addr_i[m] = 32'h1021_0000 | (m << 4);
      mst_wen_i[m]  = 1'b1;
    end
    mst_req_i = who;
    while (mst_req_i != '0 && waited < WAIT_LIMIT) begin
      @(posedge clk_i);
      g = mst_gnt_o;
      waited++;
      check_that(g == (1 << want), $sformatf("grant %b, expected master %0d", g, want));
      @(negedge clk_i);
      mst_req_i = mst_req_i & ~g;
      do begin
        want = (want + 1) % NB_MASTERS;
      end while (!who[want]);
    end
    if (mst_req_i != '0) begin
      $display("ERROR: round-robin round stalled with requests %b", mst_req_i);
      errors++;
      mst_req_i = '0;
    end
  endtask

  task automatic round_robin();
    int start;
    start = errors;
    arbitrate_round(4'b1111, 0);
    arbitrate_round(4'b0100, 2);
    arbitrate_round(4'b1111, 3);
    finish_test("round_robin", start);
  endtask

  task automatic decode_map();
    addr_t list [$];
    addr_t a;
    int    start;
    start = errors;
    for (int f = 0; f < 8; f++) begin
      list.push_back(32'h1020_0000 | (f << 16) | (f << 2));
    end
    // Out of cluster, reserved region, bit 19 set, foreign region
    list.push_back(32'h2000_0040);
    list.push_back(32'h1030_0004);
    list.push_back(32'h1028_0000);
    list.push_back(32'h1050_1234);
    for (int i = 0; i < 8; i++) begin
      a = $random(seed);
      if (i % 2 == 0) begin
        a[31:20] = 12'h102;
      end
      list.push_back(a);
    end
    foreach (list[i]) begin
      access(0, list[i], 1'b1, '0, '0, 1'b1);
    end
    finish_test("decode_map", start);
  endtask

  task automatic event_unit_merge();
    int start;
    start = errors;
    access(3, 32'h1024_0010, 1'b0, 32'h0123_4567, 4'b0011, 1'b1);
    access(3, 32'h1025_0014, 1'b0, 32'h89ab_cdef, 4'b1100, 1'b1);
    finish_test("event_unit_merge", start);
  endtask

  task automatic back_pressure();
    addr_t a_bp;
    int    start;
    int    hs_before;
    start     = errors;
    a_bp      = 32'h1022_0010;
    hs_before = hs_count[2];
    @(negedge clk_i);
    slv_gnt_i[2] = 1'b0;
    fork
      access(1, a_bp, 1'b1, '0, '0, 1'b0);
      begin
        @(negedge clk_i);
        access(0, 32'h1023_0004, 1'b1, '0, '0, 1'b0);
        check_that(!slv_gnt_i[2], "master 0 finished only after slave 2 was released");
      end
      begin
        @(negedge clk_i);
        repeat (STALL_CYCLES) begin
          @(posedge clk_i);
          check_that(!mst_gnt_o[1] && slv_req_o[2] && slv_addr_o[2] == a_bp,
                     $sformatf("stalled slave 2: gnt %b req %b addr %h",
                               mst_gnt_o[1], slv_req_o[2], slv_addr_o[2]));
        end
        @(negedge clk_i);
        slv_gnt_i[2] = 1'b1;
      end
    join
    repeat (3) @(posedge clk_i);
    check_that(hs_count[2] == hs_before + 1,
               $sformatf("slave 2 took %0d requests, expected 1", hs_count[2] - hs_before));
    finish_test("back_pressure", start);
  endtask

  task automatic response_routing();
    int start;
    start = errors;
    fork
      access(0, 32'h1020_0004, 1'b1, '0, '0, 1'b0);
      access(1, 32'h1021_0008, 1'b0, 32'h1111_2222, 4'hf, 1'b0);
      access(2, 32'h1022_000c, 1'b1, '0, '0, 1'b0);
      access(3, 32'h3000_0104, 1'b1, '0, '0, 1'b0);
    join
    // Each master had its one response, nothing may follow
    repeat (3) begin
      @(posedge clk_i);
      check_that(mst_r_valid_o == '0, $sformatf("extra response, r_valid %b", mst_r_valid_o));
    end
    finish_test("response_routing", start);
  endtask

  initial begin
    seed          = 32'h38ac_d0af;
    errors        = 0;
    checks        = 0;
    tests         = 0;
    rst_i         = 1'b1;
    mst_req_i     = '0;
    mst_addr_i    = '0;
    mst_wen_i     = '0;
    mst_wdata_i   = '0;
    mst_be_i      = '0;
    slv_gnt_i     = '1;
    slv_r_valid_i = '0;
    slv_r_rdata_i = '0;
    slv_r_opc_i   = '0;
    slv_r_id_i    = '0;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    round_robin();
    decode_map();
    event_unit_merge();
    back_pressure();
    response_routing();
    // Protocol assertions bound into the crossbar count their own failures
    errors = errors + dut.i_assert.fail_count;
    $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
